// File: include/axi_mem_defines.svh
// AXI memory bridge widths
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// Byte address width of the memory port.
`define AXI_MEM_ADDR_W 16

// Data width, one full word per beat.
`define AXI_MEM_DATA_W 32

// Transaction ID width.
`define AXI_MEM_ID_W 4

// Burst length field, beats minus one.
`define AXI_MEM_LEN_W 8

// Memory responses held in flight or buffered.
`define AXI_MEM_BUF_DEPTH 2

`endif

// File: logic/axi_mem_pkg.sv
// AXI memory bridge types
`default_nettype none

`include "axi_mem_defines.svh"

package axi_mem_pkg;

  // Plain vectors for each meaningful width.
  typedef logic [`AXI_MEM_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_MEM_DATA_W-1:0]   data_t;
  typedef logic [`AXI_MEM_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_MEM_ID_W-1:0]     id_t;
  typedef logic [`AXI_MEM_LEN_W-1:0]    len_t;

  // AR and AW command, INCR bursts of full words only.
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ax_chan_t;

  // Write data beat.
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  // Read data beat.
  typedef struct packed {
    data_t data;
    id_t   id;
    logic  last;
  } r_chan_t;

  // Write response, always OKAY.
  typedef struct packed {
    id_t id;
  } b_chan_t;

  // One beat out of a tracker.
  typedef struct packed {
    addr_t addr;
    id_t   id;
    logic  last;
    logic  write;
  } beat_t;

  // What the response side needs per beat.
  typedef struct packed {
    id_t  id;
    logic last;
    logic write;
  } meta_t;

  // Single word request to memory.
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    logic  we;
  } mem_req_t;

  typedef enum logic {
    IDLE,
    BURST
  } tracker_state_t;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
// Fall-through FIFO
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             empty;
  logic             push, pop;

  assign empty   = (cnt_q == '0);
  assign ready_o = (cnt_q < CNT_W'(DEPTH));
  assign valid_o = ~empty | valid_i;
  // Empty FIFO passes input straight through.
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];

  // Bypassed words are never stored.
  assign push = valid_i & ready_o & ~(empty & ready_i);
  assign pop  = ~empty & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/burst_tracker.sv
// Burst beat generator
`timescale 1ns/1ps
`default_nettype none

module burst_tracker import axi_mem_pkg::*; #(
  // Marks every beat as a write.
  parameter bit IS_WRITE = 1'b0
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  ax_chan_t cmd_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  output beat_t    beat_o,
  output logic     beat_valid_o,
  input  logic     beat_ready_i,
  output logic     in_burst_o
);

  // Bytes per word.
  localparam int unsigned WORD_BYTES = $bits(strb_t);

  tracker_state_t state_q, state_d;
  len_t           cnt_q, cnt_d;
  addr_t          addr_q;
  id_t            id_q;
  logic           beat_hs;

  assign beat_hs    = beat_valid_o & beat_ready_i;
  assign in_burst_o = (state_q == BURST);

  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    cmd_ready_o  = 1'b0;
    beat_o.write = IS_WRITE;
    if (state_q == IDLE) begin
      // First beat straight from the command, word aligned.
      beat_o.addr  = cmd_i.addr & ~addr_t'(WORD_BYTES - 1);
      beat_o.id    = cmd_i.id;
      beat_o.last  = (cmd_i.len == '0);
      beat_valid_o = cmd_valid_i;
      // Command is taken together with its first beat.
      cmd_ready_o  = beat_hs;
      if (beat_hs && cmd_i.len != '0) begin
        state_d = BURST;
        cnt_d   = cmd_i.len;
      end
    end else begin
      // Later beats step one word.
      beat_o.addr  = addr_q + addr_t'(WORD_BYTES);
      beat_o.id    = id_q;
      beat_o.last  = (cnt_q == len_t'(1));
      beat_valid_o = 1'b1;
      if (beat_hs) begin
        cnt_d = cnt_q - len_t'(1);
        if (beat_o.last) begin
          state_d = IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Address and ID of the last accepted beat.
  always_ff @(posedge clk_i) begin
    if (beat_hs) begin
      addr_q <= beat_o.addr;
      id_q   <= beat_o.id;
    end
  end

endmodule

`default_nettype wire

// File: logic/rw_arbiter.sv
// Read and write beat arbiter
`timescale 1ns/1ps
`default_nettype none

module rw_arbiter import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  beat_t    rd_beat_i,
  input  beat_t    wr_beat_i,
  input  logic     rd_valid_i,
  input  logic     wr_valid_i,
  output logic     rd_ready_o,
  output logic     wr_ready_o,
  input  logic     rd_in_burst_i,
  input  logic     wr_in_burst_i,
  input  w_chan_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output mem_req_t req_o,
  output meta_t    meta_o,
  output logic     req_valid_o,
  input  logic     req_ready_i,
  output logic     meta_valid_o,
  input  logic     meta_ready_i
);

  logic  wr_cand, rd_cand;
  logic  sel_d, sel_q;
  logic  lock_q;
  logic  arb_valid, arb_ready;
  beat_t beat;

  // Write beats need their W data present.
  assign wr_cand = wr_valid_i & w_valid_i;
  assign rd_cand = rd_valid_i;

  // Select, 1 picks the write side.
  always_comb begin
    sel_d = sel_q;
    if (!lock_q) begin
      if (wr_cand ^ rd_cand) begin
        sel_d = wr_cand;
      end else if (wr_cand && rd_cand) begin
        if (wr_beat_i.last && !rd_beat_i.last) begin
          // Single write ahead of a read burst.
          sel_d = 1'b1;
        end else if (wr_in_burst_i) begin
          sel_d = 1'b1;
        end else if (rd_in_burst_i) begin
          sel_d = 1'b0;
        end else begin
          // Alternate.
          sel_d = ~sel_q;
        end
      end
    end
  end

  assign beat      = sel_d ? wr_beat_i : rd_beat_i;
  assign arb_valid = sel_d ? wr_cand : rd_cand;

  // Fork, a beat goes to both outputs or to neither.
  assign arb_ready    = req_ready_i & meta_ready_i;
  assign req_valid_o  = arb_valid & meta_ready_i;
  assign meta_valid_o = arb_valid & req_ready_i;

  assign rd_ready_o = ~sel_d & rd_cand & arb_ready;
  assign wr_ready_o = sel_d & wr_cand & arb_ready;
  assign w_ready_o  = sel_d & wr_cand & arb_ready;

  assign req_o = '{
    addr:  beat.addr,
    wdata: w_i.data,
    strb:  w_i.strb,
    we:    beat.write
  };

  assign meta_o = '{
    id:    beat.id,
    last:  beat.last,
    write: beat.write
  };

  // Lock holds the choice over a stall.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= arb_valid & ~arb_ready;
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_port.sv
// Memory request port with response credit
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_defines.svh"

module mem_port import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output logic     mem_req_o,
  input  logic     mem_gnt_i,
  output addr_t    mem_addr_o,
  output data_t    mem_wdata_o,
  output strb_t    mem_strb_o,
  output logic     mem_we_o,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i,
  output data_t    resp_o,
  output logic     resp_valid_o,
  input  logic     resp_ready_i
);

  localparam int unsigned CRD_W = $clog2(`AXI_MEM_BUF_DEPTH + 1);

  logic [CRD_W-1:0] credit_q;
  logic             credit_ok;
  logic             granted, popped;

  // Room for one more response.
  assign credit_ok = (credit_q < CRD_W'(`AXI_MEM_BUF_DEPTH));

  // Request falls through and holds until granted.
  assign mem_req_o   = req_valid_i & credit_ok;
  assign req_ready_o = credit_ok & mem_gnt_i;
  assign mem_addr_o  = req_i.addr;
  assign mem_wdata_o = req_i.wdata;
  assign mem_strb_o  = req_i.strb;
  assign mem_we_o    = req_i.we;

  assign granted = mem_req_o & mem_gnt_i;
  assign popped  = resp_valid_o & resp_ready_i;

  // Outstanding plus buffered responses.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_q + CRD_W'(granted) - CRD_W'(popped);
    end
  end

  // Credit keeps this buffer from overflowing.
  sync_fifo #(
    .WIDTH ($bits(data_t)),
    .DEPTH (`AXI_MEM_BUF_DEPTH)
  ) resp_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (mem_rdata_i),
    .valid_i  (mem_rvalid_i),
    .ready_o  (),
    .data_o   (resp_o),
    .valid_o  (resp_valid_o),
    .ready_i  (resp_ready_i)
  );

endmodule

`default_nettype wire

// File: logic/resp_router.sv
// Response router to R and B
`timescale 1ns/1ps
`default_nettype none

module resp_router import axi_mem_pkg::*; (
  input  meta_t   meta_i,
  input  logic    meta_valid_i,
  output logic    meta_ready_o,
  input  data_t   resp_i,
  input  logic    resp_valid_i,
  output logic    resp_ready_o,
  output r_chan_t r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output b_chan_t b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i
);

  logic join_valid;
  logic out_ready;

  // Both heads needed.
  assign join_valid = meta_valid_i & resp_valid_i;

  assign r_valid_o = join_valid & ~meta_i.write;
  assign b_valid_o = join_valid & meta_i.write & meta_i.last;

  // Non-last write beats drop out here.
  always_comb begin
    if (!meta_i.write) begin
      out_ready = r_ready_i;
    end else if (meta_i.last) begin
      out_ready = b_ready_i;
    end else begin
      out_ready = 1'b1;
    end
  end

  // Pop both heads together.
  assign meta_ready_o = resp_valid_i & out_ready;
  assign resp_ready_o = meta_valid_i & out_ready;

  assign r_o = '{data: resp_i, id: meta_i.id, last: meta_i.last};
  assign b_o = '{id: meta_i.id};

endmodule

`default_nettype wire

// File: logic/axi_to_mem_bridge.sv
// AXI to memory bridge top
`timescale 1ns/1ps
`default_nettype none

`include "axi_mem_defines.svh"

module axi_to_mem_bridge import axi_mem_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  ax_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  input  ax_chan_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  w_chan_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  output b_chan_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  output logic     mem_req_o,
  input  logic     mem_gnt_i,
  output addr_t    mem_addr_o,
  output data_t    mem_wdata_o,
  output strb_t    mem_strb_o,
  output logic     mem_we_o,
  input  logic     mem_rvalid_i,
  input  data_t    mem_rdata_i
);

  beat_t    rd_beat, wr_beat;
  logic     rd_beat_valid, rd_beat_ready, rd_in_burst;
  logic     wr_beat_valid, wr_beat_ready, wr_in_burst;
  mem_req_t arb_req;
  meta_t    arb_meta, head_meta;
  logic     req_valid, req_ready;
  logic     meta_valid, meta_ready;
  logic     head_meta_valid, head_meta_ready;
  data_t    resp;
  logic     resp_valid, resp_ready;

  // AR into read beats.
  burst_tracker #(.IS_WRITE(1'b0)) rd_tracker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (ar_i),
    .cmd_valid_i  (ar_valid_i),
    .cmd_ready_o  (ar_ready_o),
    .beat_o       (rd_beat),
    .beat_valid_o (rd_beat_valid),
    .beat_ready_i (rd_beat_ready),
    .in_burst_o   (rd_in_burst)
  );

  // AW into write beats.
  burst_tracker #(.IS_WRITE(1'b1)) wr_tracker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_i        (aw_i),
    .cmd_valid_i  (aw_valid_i),
    .cmd_ready_o  (aw_ready_o),
    .beat_o       (wr_beat),
    .beat_valid_o (wr_beat_valid),
    .beat_ready_i (wr_beat_ready),
    .in_burst_o   (wr_in_burst)
  );

  rw_arbiter rw_arbiter_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .rd_beat_i     (rd_beat),
    .wr_beat_i     (wr_beat),
    .rd_valid_i    (rd_beat_valid),
    .wr_valid_i    (wr_beat_valid),
    .rd_ready_o    (rd_beat_ready),
    .wr_ready_o    (wr_beat_ready),
    .rd_in_burst_i (rd_in_burst),
    .wr_in_burst_i (wr_in_burst),
    .w_i           (w_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .req_o         (arb_req),
    .meta_o        (arb_meta),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready),
    .meta_valid_o  (meta_valid),
    .meta_ready_i  (meta_ready)
  );

  // One entry more than the response credit.
  sync_fifo #(
    .WIDTH ($bits(meta_t)),
    .DEPTH (`AXI_MEM_BUF_DEPTH + 1)
  ) meta_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .data_i   (arb_meta),
    .valid_i  (meta_valid),
    .ready_o  (meta_ready),
    .data_o   (head_meta),
    .valid_o  (head_meta_valid),
    .ready_i  (head_meta_ready)
  );

  mem_port mem_port_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (arb_req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_strb_o   (mem_strb_o),
    .mem_we_o     (mem_we_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .resp_o       (resp),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready)
  );

  resp_router resp_router_i (
    .meta_i       (head_meta),
    .meta_valid_i (head_meta_valid),
    .meta_ready_o (head_meta_ready),
    .resp_i       (resp),
    .resp_valid_i (resp_valid),
    .resp_ready_o (resp_ready),
    .r_o          (r_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .b_o          (b_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i)
  );

endmodule

`default_nettype wire

// File: tb/axi_mem_checker.sv
// Bridge handshake assertions
`timescale 1ns/1ps
`default_nettype none

module axi_mem_checker import axi_mem_pkg::*; (
  input logic     clk_i,
  input logic     arst_n_i,
  input ax_chan_t ar_i,
  input logic     ar_valid_i,
  input logic     ar_ready_i,
  input ax_chan_t aw_i,
  input logic     aw_valid_i,
  input logic     aw_ready_i,
  input w_chan_t  w_i,
  input logic     w_valid_i,
  input logic     w_ready_i,
  input r_chan_t  r_i,
  input logic     r_valid_i,
  input logic     r_ready_i,
  input b_chan_t  b_i,
  input logic     b_valid_i,
  input logic     b_ready_i,
  input logic     mem_req_i
);

  // Count of failed assertions, polled by the testbench.
  int unsigned fail_cnt = 0;

  // AR payload holds until taken.
  ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
  else begin
    $error("AR dropped or changed while stalled.");
    fail_cnt++;
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
  else begin
    $error("AW dropped or changed while stalled.");
    fail_cnt++;
  end

  w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
  else begin
    $error("W dropped or changed while stalled.");
    fail_cnt++;
  end

  // Response side is driven by the bridge.
  r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_i))
  else begin
    $error("R dropped or changed while stalled.");
    fail_cnt++;
  end

  b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_i))
  else begin
    $error("B dropped or changed while stalled.");
    fail_cnt++;
  end

  // No memory traffic under reset.
  req_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !mem_req_i)
  else begin
    $error("Memory request raised during reset.");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: tb/tb_axi_to_mem.sv
// AXI to memory bridge testbench
`timescale 1ns/1ps
`default_nettype none

module tb_axi_to_mem import axi_mem_pkg::*; ();

  localparam int NUM_PAIRS = 6;
  localparam int NUM_MIX   = 16;
  localparam int NUM_TXN   = 2 * NUM_PAIRS + 2 * NUM_MIX;
  localparam int MEM_WORDS = 256;

  // One open burst of the model.
  typedef struct packed {
    id_t         id;
    logic [7:0]  word;
    len_t        len;
    logic [31:0] w_end;
  } burst_t;

  logic     clk = 1'b0;
  logic     arst_n = 1'b0;
  ax_chan_t ar = '0;
  logic     ar_valid = 1'b0;
  logic     ar_ready;
  ax_chan_t aw = '0;
  logic     aw_valid = 1'b0;
  logic     aw_ready;
  w_chan_t  w = '0;
  logic     w_valid = 1'b0;
  logic     w_ready;
  r_chan_t  r;
  logic     r_valid;
  logic     r_ready = 1'b0;
  b_chan_t  b;
  logic     b_valid;
  logic     b_ready = 1'b0;
  logic     mem_req;
  logic     mem_gnt = 1'b0;
  addr_t    mem_addr;
  data_t    mem_wdata;
  strb_t    mem_strb;
  logic     mem_we;
  logic     mem_rvalid = 1'b0;
  data_t    mem_rdata = '0;

  integer     seed = 32'hd997;
  data_t      mem_model [MEM_WORDS];
  data_t      ref_mem [MEM_WORDS];
  burst_t     rd_exp_q[$];
  burst_t     wr_exp_q[$];
  logic [7:0] rd_addr_q[$];
  logic [7:0] wr_addr_q[$];
  int         resp_due_q[$];
  data_t      resp_data_q[$];
  len_t       r_beat_cnt [16];
  int         cycle = 0;
  int         last_due = 0;
  int         w_needed = 0;
  int         w_accepted = 0;
  int         rd_done = 0;
  int         wr_done = 0;
  int         errors = 0;

  axi_to_mem_bridge axi_to_mem_bridge_i (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .ar_i         (ar),
    .ar_valid_i   (ar_valid),
    .ar_ready_o   (ar_ready),
    .aw_i         (aw),
    .aw_valid_i   (aw_valid),
    .aw_ready_o   (aw_ready),
    .w_i          (w),
    .w_valid_i    (w_valid),
    .w_ready_o    (w_ready),
    .r_o          (r),
    .r_valid_o    (r_valid),
    .r_ready_i    (r_ready),
    .b_o          (b),
    .b_valid_o    (b_valid),
    .b_ready_i    (b_ready),
    .mem_req_o    (mem_req),
    .mem_gnt_i    (mem_gnt),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_strb_o   (mem_strb),
    .mem_we_o     (mem_we),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  bind axi_to_mem_bridge axi_mem_checker axi_mem_checker_i (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .ar_i (ar_i), .ar_valid_i (ar_valid_i), .ar_ready_i (ar_ready_o),
    .aw_i (aw_i), .aw_valid_i (aw_valid_i), .aw_ready_i (aw_ready_o),
    .w_i (w_i), .w_valid_i (w_valid_i), .w_ready_i (w_ready_o),
    .r_i (r_o), .r_valid_i (r_valid_o), .r_ready_i (r_ready_i),
    .b_i (b_o), .b_valid_i (b_valid_o), .b_ready_i (b_ready_i),
    .mem_req_i (mem_req_o)
  );

  always #4 clk = ~clk;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Start pattern, unique per word.
  function automatic data_t fill_word(input int idx);
    logic [7:0] a;
    a = 8'(idx);
    return {a ^ 8'ha5, ~a, a, a ^ 8'h3c};
  endfunction

  // Byte-wise merge under strobes.
  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    int    k;
    res = old;
    for (k = 0; k < 4; k++) begin
      if (strb[k]) res[8*k +: 8] = wdata[8*k +: 8];
    end
    return res;
  endfunction

  // Oldest open burst with this ID, or -1.
  function automatic int first_with_id(input logic is_wr, input id_t id);
    int k;
    first_with_id = -1;
    if (is_wr) begin
      for (k = wr_exp_q.size() - 1; k >= 0; k--) begin
        if (wr_exp_q[k].id == id) first_with_id = k;
      end
    end else begin
      for (k = rd_exp_q.size() - 1; k >= 0; k--) begin
        if (rd_exp_q[k].id == id) first_with_id = k;
      end
    end
  endfunction

  // Random burst inside a word window, start byte possibly unaligned.
  function automatic ax_chan_t random_burst(input int base, input int span, input int len_mask);
    ax_chan_t c;
    logic [7:0] word;
    word   = 8'(base + ($random(seed) & 32'h7fff_ffff) % span);
    c.id   = id_t'($random(seed));
    c.len  = len_t'($random(seed) & len_mask);
    c.addr = {6'd0, word, 2'd0} | addr_t'($random(seed) & 3);
    return c;
  endfunction

  task automatic send_ar(input ax_chan_t cmd);
    @(negedge clk);
    repeat ($random(seed) & 3) @(negedge clk);
    ar = cmd;
    ar_valid = 1'b1;
    @(posedge clk);
    while (!ar_ready) @(posedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
  endtask

  task automatic send_aw(input ax_chan_t cmd);
    @(negedge clk);
    repeat ($random(seed) & 3) @(negedge clk);
    aw = cmd;
    aw_valid = 1'b1;
    @(posedge clk);
    while (!aw_ready) @(posedge clk);
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  // W beats with random gaps, data and strobes.
  task automatic send_w(input len_t len);
    int n;
    for (n = 0; n <= int'(len); n++) begin
      @(negedge clk);
      w_valid = 1'b0;
      repeat ($random(seed) & 1) @(negedge clk);
      w.data  = data_t'($random(seed));
      w.strb  = strb_t'($random(seed));
      w_valid = 1'b1;
      @(posedge clk);
      while (!w_ready) @(posedge clk);
    end
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  // Memory grant, ready toggling and in-order responses.
  always @(negedge clk) begin
    cycle      = cycle + 1;
    mem_gnt    = ($random(seed) & 3) != 0;
    r_ready    = ($random(seed) & 3) != 0;
    b_ready    = ($random(seed) & 1) != 0;
    mem_rvalid = 1'b0;
    if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
      void'(resp_due_q.pop_front());
      mem_rdata  = resp_data_q.pop_front();
      mem_rvalid = 1'b1;
    end
  end

  // Scoreboard, all handshakes seen at the rising edge.
  always @(posedge clk) begin : monitor
    burst_t     bst;
    int         idx;
    int         due;
    logic       wr_gnt;
    logic       rd_gnt;
    logic [7:0] word;
    data_t      rdata;
    if (axi_to_mem_bridge_i.axi_mem_checker_i.fail_cnt != 0) begin
      fail_now("A handshake assertion in the checker failed.");
    end
    if (arst_n) begin
      // Commands open bursts and expected word addresses.
      if (aw_valid && aw_ready) begin
        w_needed = w_needed + int'(aw.len) + 1;
        bst = '{id: aw.id, word: aw.addr[9:2], len: aw.len, w_end: w_needed};
        wr_exp_q.push_back(bst);
        for (idx = 0; idx <= int'(aw.len); idx++) wr_addr_q.push_back(aw.addr[9:2] + 8'(idx));
      end
      if (ar_valid && ar_ready) begin
        bst = '{id: ar.id, word: ar.addr[9:2], len: ar.len, w_end: 0};
        rd_exp_q.push_back(bst);
        for (idx = 0; idx <= int'(ar.len); idx++) rd_addr_q.push_back(ar.addr[9:2] + 8'(idx));
      end
      // A W beat is taken exactly with its write request.
      wr_gnt = mem_req && mem_gnt && mem_we;
      rd_gnt = mem_req && mem_gnt && !mem_we;
      check_value("w_ready_o", w_valid && w_ready, wr_gnt);
      rdata = '0;
      if (wr_gnt) begin
        if (wr_addr_q.size() == 0) fail_now("Write request without an open write burst.");
        word = wr_addr_q.pop_front();
        check_value("mem_addr_o", mem_addr, {6'd0, word, 2'd0});
        check_value("mem_wdata_o", mem_wdata, w.data);
        check_value("mem_strb_o", mem_strb, w.strb);
        ref_mem[word] = merge_bytes(ref_mem[word], w.data, w.strb);
        mem_model[mem_addr[9:2]] = merge_bytes(mem_model[mem_addr[9:2]], mem_wdata, mem_strb);
        w_accepted++;
      end
      if (rd_gnt) begin
        if (rd_addr_q.size() == 0) fail_now("Read request without an open read burst.");
        word = rd_addr_q.pop_front();
        check_value("mem_addr_o", mem_addr, {6'd0, word, 2'd0});
        rdata = mem_model[mem_addr[9:2]];
      end
      // Response 1 to 3 cycles later, never overtaking.
      if (wr_gnt || rd_gnt) begin
        due = cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        resp_due_q.push_back(due);
        resp_data_q.push_back(rdata);
      end
      if (r_valid && r_ready) begin
        idx = first_with_id(1'b0, r.id);
        if (idx < 0) fail_now("Read beat with an ID that has no open burst.");
        bst  = rd_exp_q[idx];
        word = bst.word + r_beat_cnt[r.id];
        check_value("r_o.data", r.data, ref_mem[word]);
        check_value("r_o.last", r.last, r_beat_cnt[r.id] == bst.len);
        if (r.last) begin
          rd_exp_q.delete(idx);
          r_beat_cnt[r.id] = '0;
          rd_done++;
        end else begin
          r_beat_cnt[r.id]++;
        end
      end
      if (b_valid && b_ready) begin
        idx = first_with_id(1'b1, b.id);
        if (idx < 0) fail_now("Write response with an ID that has no open burst.");
        if (w_accepted < int'(wr_exp_q[idx].w_end)) begin
          fail_now("Write response came before all its W beats were taken.");
        end
        wr_exp_q.delete(idx);
        wr_done++;
      end
    end
  end

  // Budget of 200 cycles per transaction.
  initial begin : watchdog
    repeat (NUM_TXN * 200) @(posedge clk);
    fail_now("Watchdog expired before all transactions completed.");
  end

  initial begin : stimulus
    ax_chan_t cmd;
    int       i;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end
    for (i = 0; i < 16; i++) r_beat_cnt[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("ar_ready_o", ar_ready, 0);
    check_value("aw_ready_o", aw_ready, 0);
    check_value("w_ready_o", w_ready, 0);
    check_value("r_valid_o", r_valid, 0);
    check_value("b_valid_o", b_valid, 0);
    check_value("mem_req_o", mem_req, 0);

    // Write a range, then read it back after its B.
    for (i = 0; i < NUM_PAIRS; i++) begin
      cmd = random_burst(0, 240, 15);
      fork
        send_aw(cmd);
        send_w(cmd.len);
      join
      wait (wr_done == i + 1);
      cmd.id = id_t'($random(seed));
      send_ar(cmd);
      wait (rd_done == i + 1);
    end

    // Writes to the low half and reads of the high half at once.
    fork
      begin : write_side
        ax_chan_t wcmd;
        int       k;
        for (k = 0; k < NUM_MIX; k++) begin
          wcmd = random_burst(0, 112, 7);
          fork
            send_aw(wcmd);
            send_w(wcmd.len);
          join
        end
      end
      begin : read_side
        int k;
        for (k = 0; k < NUM_MIX; k++) begin
          send_ar(random_burst(128, 112, 7));
        end
      end
    join
    wait (rd_done == NUM_PAIRS + NUM_MIX && wr_done == NUM_PAIRS + NUM_MIX);
    repeat (10) @(posedge clk);

    if (rd_exp_q.size() != 0 || wr_exp_q.size() != 0 || resp_due_q.size() != 0) begin
      $display("Bursts or memory responses were still open at the end of the run.");
      errors++;
    end
    if (errors == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "Run ended with open transactions.");
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
logic/axi_mem_pkg.sv
logic/sync_fifo.sv
logic/burst_tracker.sv
logic/rw_arbiter.sv
logic/mem_port.sv
logic/resp_router.sv
logic/axi_to_mem_bridge.sv
tb/axi_mem_checker.sv
tb/tb_axi_to_mem.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the AXI to memory bridge testbench with Verilator.
set -u
cd "$(dirname "$0")"

obj_dir="obj_dir"
log_file="sim.log"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_axi_to_mem --Mdir "$obj_dir" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$obj_dir/tb_sim" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
fi

grep -q "SIMULATION PASSED" "$log_file"
if [ $? -ne 0 ]; then
  echo "Test run failed, see $log_file"
  exit 1
fi
echo "Test run succeeded"
exit 0
